// File: hw/mfPkg.sv
//----------------------------------------
// matched filter shared types and widths
// sample, coefficient, tap command, MAC operand
//----------------------------------------
package mfPkg;

   //----------------------------------------
   // fixed widths
   //----------------------------------------
   // one real or imaginary component, Q1.17
   localparam int sampleW = 18;
   // full product of two components
   localparam int prodW = 2 * sampleW;
   // product plus two guard bits
   localparam int accW = prodW + 2;
   // taps per symbol, two symbols of 2x samples
   localparam int numTaps = 4;

   //----------------------------------------
   // data types
   //----------------------------------------
   typedef logic signed [sampleW-1:0] sampleT;
   typedef logic signed [sampleW-1:0] coeffT;
   typedef logic signed [prodW-1:0] prodT;
   typedef logic signed [accW-1:0] accT;
   typedef logic [$clog2(numTaps)-1:0] tapIdxT;

   // complex sample, i real and q imag
   typedef struct packed {
      sampleT i;
      sampleT q;
   } cplxSampleT;

   // complex tap, a real and b imag
   typedef struct packed {
      coeffT a;
      coeffT b;
   } cplxCoeffT;

   // index 0 meets the oldest sample
   typedef cplxCoeffT [numTaps-1:0] coeffSetT;

   // sequencer command to the window
   typedef struct packed {
      logic valid;
      logic first;
      logic last;
      tapIdxT idx;
   } tapCtlT;

   // operands of one tap into the MAC
   typedef struct packed {
      cplxSampleT sample;
      cplxCoeffT coeff;
      logic valid;
      logic first;
      logic last;
   } macOpT;

endpackage

// File: hw/symTimer.sv
//----------------------------------------
// symbol timer, fixed divider
// 2x sample strobe and symbol strobe
//----------------------------------------
`timescale 1ns/1ns

module symTimer #(
   parameter int halfPeriod = 5
) (
   input  logic clk,
   input  logic reset,
   output logic sym2xEn,
   output logic symEn
);

   localparam int cntW = $clog2(halfPeriod);

   // down-counter, wraps once per half symbol
   logic [cntW-1:0] count;
   // high on every second 2x strobe
   logic phase;
   logic wrap;

   assign wrap = (count == '0);

   always_ff @(posedge clk) begin
      if (reset) begin
         count   <= cntW'(halfPeriod - 1);
         phase   <= 1'b0;
         sym2xEn <= 1'b0;
         symEn   <= 1'b0;
      end else begin
         // strobes are registered off the wrap
         sym2xEn <= wrap;
         symEn   <= wrap & phase;
         if (wrap) begin
            count <= cntW'(halfPeriod - 1);
            // alternate between half and full symbol
            phase <= ~phase;
         end else begin
            count <= count - 1'b1;
         end
      end
   end

endmodule

// File: hw/tapSequencer.sv
//----------------------------------------
// tap sequencer FSM
// four tap cycles after each symbol strobe
//----------------------------------------
`timescale 1ns/1ns

module tapSequencer (
   input  logic clk,
   input  logic reset,
   input  logic symEn,
   output mfPkg::tapCtlT tapCtl
);

   import mfPkg::*;

   typedef enum logic {
      IDLE,
      RUN
   } stateT;

   stateT state;
   stateT nextState;
   // tap under way while in RUN
   tapIdxT tapCnt;
   logic lastTap;

   assign lastTap = (tapCnt == tapIdxT'(numTaps - 1));

   //----------------------------------------
   // state transitions
   //----------------------------------------
   always_comb begin
      nextState = state;
      case (state)
         IDLE: if (symEn) nextState = RUN;
         // leave after the last tap
         RUN: if (lastTap) nextState = IDLE;
         default: nextState = IDLE;
      endcase
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= IDLE;
         tapCnt <= '0;
      end else begin
         state <= nextState;
         // count only while taps are issued
         if (state == RUN) begin
            tapCnt <= tapCnt + 1'b1;
         end else begin
            tapCnt <= '0;
         end
      end
   end

   //----------------------------------------
   // command to the window
   //----------------------------------------
   always_comb begin
      tapCtl.valid = (state == RUN);
      // first and last marked here, MAC just follows
      tapCtl.first = (state == RUN) && (tapCnt == '0);
      tapCtl.last  = (state == RUN) && lastTap;
      tapCtl.idx   = tapCnt;
   end

endmodule

// File: hw/sampleWindow.sv
//----------------------------------------
// sample shift register and symbol window
// per-tap operand select for the MAC
//----------------------------------------
`timescale 1ns/1ns

module sampleWindow #(
   parameter mfPkg::coeffSetT coeffs = '0
) (
   input  logic clk,
   input  logic reset,
   input  logic sym2xEn,
   input  logic symEn,
   input  mfPkg::cplxSampleT sample,
   input  mfPkg::tapCtlT tapCtl,
   output mfPkg::macOpT macOp
);

   import mfPkg::*;

   // entry 0 newest, shifts on every 2x strobe
   cplxSampleT [numTaps-1:0] shiftReg;
   // entry 0 oldest (x0), stable for a whole symbol
   cplxSampleT [numTaps-1:0] window;

   // registered operands
   cplxSampleT opSample;
   cplxCoeffT opCoeff;
   logic opValid;
   logic opFirst;
   logic opLast;

   //----------------------------------------
   // sample capture
   //----------------------------------------
   always_ff @(posedge clk) begin
      if (reset) begin
         shiftReg <= '0;
      end else if (sym2xEn) begin
         shiftReg <= {shiftReg[numTaps-2:0], sample};
      end
   end

   // latch pre-shift contents, so the sample taken
   // on this same edge stays out of the window
   always_ff @(posedge clk) begin
      if (symEn) begin
         for (int k = 0; k < numTaps; k++) begin
            // reverse order, oldest to entry 0
            window[k] <= shiftReg[numTaps-1-k];
         end
      end
   end

   //----------------------------------------
   // operand select per tap
   //----------------------------------------
   always_ff @(posedge clk) begin
      if (tapCtl.valid) begin
         opSample <= window[tapCtl.idx];
         opCoeff  <= coeffs[tapCtl.idx];
      end
   end

   // flags only meaningful with valid
   always_ff @(posedge clk) begin
      if (reset) begin
         opValid <= 1'b0;
         opFirst <= 1'b0;
         opLast  <= 1'b0;
      end else begin
         opValid <= tapCtl.valid;
         opFirst <= tapCtl.valid & tapCtl.first;
         opLast  <= tapCtl.valid & tapCtl.last;
      end
   end

   assign macOp = '{sample: opSample, coeff: opCoeff,
                    valid: opValid, first: opFirst, last: opLast};

endmodule

// File: hw/complexMac.sv
//----------------------------------------
// time-shared complex MAC, mf0 and mf1
// products, signed accumulation, output truncation
//----------------------------------------
`timescale 1ns/1ns

module complexMac #(
   parameter int mfBits = 12
) (
   input  logic clk,
   input  logic reset,
   input  mfPkg::macOpT macOp,
   output logic signed [mfBits-1:0] mf0I,
   output logic signed [mfBits-1:0] mf0Q,
   output logic signed [mfBits-1:0] mf1I,
   output logic signed [mfBits-1:0] mf1Q,
   output logic mfValid
);

   import mfPkg::*;

   // mf0I, mf0Q, mf1I, mf1Q in that order
   localparam int numSums = 4;

   // cross products of one tap
   prodT prodAI;
   prodT prodBQ;
   prodT prodAQ;
   prodT prodBI;
   // flags delayed alongside the products
   logic prodValid;
   logic prodFirst;
   logic prodLast;

   accT term [numSums];
   accT acc [numSums];
   accT accNext [numSums];
   logic signed [mfBits-1:0] mfOut [numSums];

   //----------------------------------------
   // product stage
   //----------------------------------------
   always_ff @(posedge clk) begin
      prodAI <= macOp.sample.i * macOp.coeff.a;
      prodBQ <= macOp.sample.q * macOp.coeff.b;
      prodAQ <= macOp.sample.q * macOp.coeff.a;
      prodBI <= macOp.sample.i * macOp.coeff.b;
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         prodValid <= 1'b0;
         prodFirst <= 1'b0;
         prodLast  <= 1'b0;
      end else begin
         prodValid <= macOp.valid;
         prodFirst <= macOp.first;
         prodLast  <= macOp.last;
      end
   end

   //----------------------------------------
   // add/subtract accumulation
   //----------------------------------------
   always_comb begin
      // x * c, real and imag
      term[0] = accT'(prodAI) - accT'(prodBQ);
      term[1] = accT'(prodAQ) + accT'(prodBI);
      // x * conj(c), b terms flip sign
      term[2] = accT'(prodAI) + accT'(prodBQ);
      term[3] = accT'(prodAQ) - accT'(prodBI);
      for (int k = 0; k < numSums; k++) begin
         // first tap reloads, no carry-over between symbols
         accNext[k] = prodFirst ? term[k] : acc[k] + term[k];
      end
   end

   always_ff @(posedge clk) begin
      if (prodValid) begin
         for (int k = 0; k < numSums; k++) begin
            acc[k] <= accNext[k];
         end
      end
   end

   //----------------------------------------
   // output register
   //----------------------------------------
   // top bits taken straight off the final sum,
   // which is a floor divide
   always_ff @(posedge clk) begin
      if (reset) begin
         mfValid <= 1'b0;
         for (int k = 0; k < numSums; k++) begin
            mfOut[k] <= '0;
         end
      end else begin
         mfValid <= prodValid & prodLast;
         if (prodValid && prodLast) begin
            for (int k = 0; k < numSums; k++) begin
               mfOut[k] <= accNext[k][accW-1 -: mfBits];
            end
         end
      end
   end

   assign mf0I = mfOut[0];
   assign mf0Q = mfOut[1];
   assign mf1I = mfOut[2];
   assign mf1Q = mfOut[3];

endmodule

// File: hw/mfFilter.sv
//----------------------------------------
// matched filter top level
// timer, sequencer, window and MAC
//----------------------------------------
`timescale 1ns/1ns

module mfFilter #(
   parameter int halfPeriod = 5,
   parameter int mfBits = 12,
   parameter mfPkg::coeffSetT coeffs = '0
) (
   input  logic clk,
   input  logic reset,
   input  mfPkg::cplxSampleT sample,
   output logic sym2xEn,
   output logic symEn,
   output logic signed [mfBits-1:0] mf0I,
   output logic signed [mfBits-1:0] mf0Q,
   output logic signed [mfBits-1:0] mf1I,
   output logic signed [mfBits-1:0] mf1Q,
   output logic mfValid
);

   import mfPkg::*;

   // sequencer to window
   tapCtlT tapCtl;
   // window to MAC
   macOpT macOp;

   // strobes also go out to the sample source
   symTimer #(
      .halfPeriod(halfPeriod)
   ) symTimer_inst (
      .clk    (clk),
      .reset  (reset),
      .sym2xEn(sym2xEn),
      .symEn  (symEn)
   );

   tapSequencer tapSequencer_inst (
      .clk   (clk),
      .reset (reset),
      .symEn (symEn),
      .tapCtl(tapCtl)
   );

   sampleWindow #(
      .coeffs(coeffs)
   ) sampleWindow_inst (
      .clk    (clk),
      .reset  (reset),
      .sym2xEn(sym2xEn),
      .symEn  (symEn),
      .sample (sample),
      .tapCtl (tapCtl),
      .macOp  (macOp)
   );

   complexMac #(
      .mfBits(mfBits)
   ) complexMac_inst (
      .clk    (clk),
      .reset  (reset),
      .macOp  (macOp),
      .mf0I   (mf0I),
      .mf0Q   (mf0Q),
      .mf1I   (mf1I),
      .mf1Q   (mf1Q),
      .mfValid(mfValid)
   );

endmodule

// File: sim/mfFilterTb.sv
//----------------------------------------
// matched filter testbench
// file and LFSR stimulus, reference model, checks
//----------------------------------------
`timescale 1ns/1ns

module mfFilterTb;

   import mfPkg::*;

   localparam int halfPeriod = 5;
   localparam int mfBits = 12;
   // bits dropped from the 38-bit sum
   localparam int dropBits = 38 - mfBits;
   localparam int latency = 7;
   localparam int numRandom = 40;
   // taps 0..3 as (a,b) in units of 1/16 are (3,-1) (7,2) (14,6) (-4,6)
   localparam coeffSetT tbCoeffs = {18'h38000, 18'h0c000, 18'h1c000, 18'h0c000,
                                    18'h0e000, 18'h04000, 18'h06000, 18'h3e000};
   // per-test error slots
   localparam int idReset = 0;
   localparam int idCadence = 1;
   localparam int idLatency = 2;
   localparam int idDirected = 3;
   localparam int idRandom = 4;
   localparam int idCarry = 5;
   localparam int numTests = 6;

   typedef struct packed {
      logic signed [31:0] mf0I;
      logic signed [31:0] mf0Q;
      logic signed [31:0] mf1I;
      logic signed [31:0] mf1Q;
   } resultT;

   logic clk = 1'b0;
   logic reset;
   cplxSampleT sample;
   logic sym2xEn;
   logic symEn;
   logic signed [mfBits-1:0] mf0I;
   logic signed [mfBits-1:0] mf0Q;
   logic signed [mfBits-1:0] mf1I;
   logic signed [mfBits-1:0] mf1Q;
   logic mfValid;

   int errCount [numTests];
   int resultCount = 0;
   int fileSyms = 0;
   int cycle = 0;
   int pulseCount = 0;
   int lastPulse = -1;
   logic [31:0] lfsrState = 32'h39aa_e294;
   // last four captured samples with the oldest first
   cplxSampleT history [$];
   cplxSampleT fileSampleQ [$];
   resultT fileExpQ [$];
   resultT modelQ [$];
   int symCycleQ [$];

   mfFilter #(
      .halfPeriod(halfPeriod),
      .mfBits    (mfBits),
      .coeffs    (tbCoeffs)
   ) mfFilter_inst (
      .clk    (clk),
      .reset  (reset),
      .sample (sample),
      .sym2xEn(sym2xEn),
      .symEn  (symEn),
      .mf0I   (mf0I),
      .mf0Q   (mf0Q),
      .mf1I   (mf1I),
      .mf1Q   (mf1Q),
      .mfValid(mfValid)
   );

   always #2 clk = ~clk;

   //----------------------------------------
   // stimulus sources
   //----------------------------------------
   // Galois form with taps 32 22 2 1
   function automatic logic lfsrBit();
      logic b;
      b = lfsrState[0];
      lfsrState = lfsrState >> 1;
      if (b) lfsrState = lfsrState ^ 32'h8020_0003;
      return b;
   endfunction

   function automatic cplxSampleT randomSample();
      logic [35:0] bits;
      for (int n = 0; n < 36; n++) begin
         bits = {bits[34:0], lfsrBit()};
      end
      return cplxSampleT'(bits);
   endfunction

   // file samples first and random ones after them
   function automatic cplxSampleT nextSample();
      if (fileSampleQ.size() > 0) return fileSampleQ.pop_front();
      return randomSample();
   endfunction

   function automatic int signExtend(input int v);
      if (v >= (1 << (mfBits - 1))) return v - (1 << mfBits);
      return v;
   endfunction

   task automatic readStimulus();
      int fd;
      int n;
      int v [4];
      string line;
      cplxSampleT s;
      resultT e;
      fd = $fopen("sim/mfStimulus.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file sim/mfStimulus.txt");
         errCount[idDirected]++;
      end else begin
         while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            // S records hold sample i q and E records hold mf0I mf0Q mf1I mf1Q
            if (n > 1 && line[0] == "S") begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h", v[0], v[1]);
               s.i = v[0][17:0];
               s.q = v[1][17:0];
               if (n == 2) fileSampleQ.push_back(s);
            end else if (n > 1 && line[0] == "E") begin
               n = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h",
                           v[0], v[1], v[2], v[3]);
               e.mf0I = signExtend(v[0]);
               e.mf0Q = signExtend(v[1]);
               e.mf1I = signExtend(v[2]);
               e.mf1Q = signExtend(v[3]);
               if (n == 4) fileExpQ.push_back(e);
            end
         end
         $fclose(fd);
      end
      fileSyms = fileExpQ.size();
   endtask

   //----------------------------------------
   // reference model and checks
   //----------------------------------------
   // x*c and x*conj(c) summed over the window and floored
   function automatic resultT modelResult(input cplxSampleT [numTaps-1:0] win);
      longint si;
      longint sq;
      longint ca;
      longint cb;
      longint sum [4];
      resultT r;
      sum = '{0, 0, 0, 0};
      for (int k = 0; k < numTaps; k++) begin
         si = $signed(win[k].i);
         sq = $signed(win[k].q);
         ca = $signed(tbCoeffs[k].a);
         cb = $signed(tbCoeffs[k].b);
         sum[0] += ca * si - cb * sq;
         sum[1] += ca * sq + cb * si;
         sum[2] += ca * si + cb * sq;
         sum[3] += ca * sq - cb * si;
      end
      r.mf0I = sum[0] >>> dropBits;
      r.mf0Q = sum[1] >>> dropBits;
      r.mf1I = sum[2] >>> dropBits;
      r.mf1Q = sum[3] >>> dropBits;
      return r;
   endfunction

   task automatic checkValue(input string name, input int got, input int exp, input int id);
      if (got != exp) begin
         $display("Error at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
         errCount[id]++;
      end
   endtask

   task automatic compareResult(input resultT got, input resultT exp, input int id);
      checkValue("mf0I", got.mf0I, exp.mf0I, id);
      checkValue("mf0Q", got.mf0Q, exp.mf0Q, id);
      checkValue("mf1I", got.mf1I, exp.mf1I, id);
      checkValue("mf1Q", got.mf1Q, exp.mf1Q, id);
   endtask

   // all four outputs still at their reset value
   task automatic checkIdle();
      resultT got;
      got = '{mf0I: mf0I, mf0Q: mf0Q, mf1I: mf1I, mf1Q: mf1Q};
      compareResult(got, '0, idReset);
   endtask

   // one sym2xEn per halfPeriod and symEn on every second one
   task automatic checkStrobes();
      if (symEn && !sym2xEn) begin
         $display("symEn came without sym2xEn at %0t ns", $time);
         errCount[idCadence]++;
      end
      if (sym2xEn) begin
         pulseCount++;
         if (lastPulse >= 0) checkValue("sym2xEn period", cycle - lastPulse, halfPeriod,
                                        idCadence);
         checkValue("symEn", symEn, (pulseCount % 2 == 0), idCadence);
         lastPulse = cycle;
      end
   endtask

   task automatic checkResult();
      resultT got;
      got = '{mf0I: mf0I, mf0Q: mf0Q, mf1I: mf1I, mf1Q: mf1Q};
      if (modelQ.size() == 0) begin
         $display("mfValid at %0t ns with no symbol pending", $time);
         errCount[idLatency]++;
      end else begin
         checkValue("mfValid latency", cycle - symCycleQ.pop_front(), latency, idLatency);
         compareResult(got, modelQ.pop_front(),
                       (resultCount < fileSyms) ? idDirected : idRandom);
         if (resultCount < fileSyms) compareResult(got, fileExpQ.pop_front(), idDirected);
         // zero window right after nonzero symbols
         if (resultCount == fileSyms - 1) compareResult(got, '0, idCarry);
      end
      resultCount++;
   endtask

   // drive on the falling edge where outputs are stable
   always @(negedge clk) begin : monitor
      cplxSampleT s;
      cplxSampleT [numTaps-1:0] win;
      if (!reset) begin
         cycle++;
         checkStrobes();
         if (sym2xEn) begin
            // window excludes the sample taken on this edge
            if (symEn) begin
               for (int k = 0; k < numTaps; k++) win[k] = history[k];
               modelQ.push_back(modelResult(win));
               symCycleQ.push_back(cycle);
            end
            s = nextSample();
            sample = s;
            history.push_back(s);
            void'(history.pop_front());
         end
         if (mfValid) checkResult();
      end
   end

   //----------------------------------------
   // test sequence
   //----------------------------------------
   task automatic waitResults(input int target, output bit ok);
      int limit;
      int n;
      limit = (target - resultCount + 4) * 2 * halfPeriod;
      n = 0;
      while (resultCount < target && n < limit) begin
         @(posedge clk);
         n++;
      end
      ok = (resultCount >= target);
   endtask

   task automatic report(input string name, input int id);
      $display("test %-8s finished with %0d errors", name, errCount[id]);
   endtask

   task automatic runTests(output bit timedOut);
      int n;
      bit ok;
      timedOut = 1'b1;
      for (n = 0; n < 5; n++) begin
         @(negedge clk);
         checkValue("sym2xEn", sym2xEn, 0, idReset);
         checkValue("symEn", symEn, 0, idReset);
         checkValue("mfValid", mfValid, 0, idReset);
         checkIdle();
      end
      reset = 1'b0;
      // outputs stay zero until the first result
      n = 0;
      @(negedge clk);
      while (!mfValid && n < 100) begin
         checkIdle();
         n++;
         @(negedge clk);
      end
      if (!mfValid) begin
         $display("timeout: no mfValid after reset release");
         return;
      end
      report("reset", idReset);
      waitResults(fileSyms, ok);
      if (!ok) begin
         $display("timeout: the directed symbols did not all produce a result");
         return;
      end
      report("directed", idDirected);
      report("carry", idCarry);
      waitResults(fileSyms + numRandom, ok);
      if (!ok) begin
         $display("timeout: the random symbols did not all produce a result");
         return;
      end
      report("random", idRandom);
      report("cadence", idCadence);
      report("latency", idLatency);
      timedOut = 1'b0;
   endtask

   initial begin : main
      int total;
      bit timedOut;
      reset = 1'b1;
      sample = '0;
      for (int k = 0; k < numTests; k++) errCount[k] = 0;
      // shift register is zero after reset
      for (int k = 0; k < numTaps; k++) history.push_back(cplxSampleT'(0));
      readStimulus();
      runTests(timedOut);
      total = 0;
      for (int k = 0; k < numTests; k++) total += errCount[k];
      $display("summary: %0d results checked, %0d errors in total", resultCount, total);
      if (!timedOut && total == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

endmodule

// File: sim/mfStimulus.txt
# S records: sample i q, 18-bit hex, in stream order from the first sym2xEn
# E records: expected mf0I mf0Q mf1I mf1Q, 12-bit hex, one per symbol in order
S 00000 00000
S 00000 00000
S 10000 00000
S 00000 00000
S 00000 00000
S 00000 00000
S 00000 00000
S 10000 00000
S 00000 00000
S 00000 00000
S 00000 00000
S 00000 00000
S 00000 10000
S 00000 00000
S 00000 00000
S 20000 20000
S 20000 20000
S 20000 20000
S 20000 20000
S 3ffff 00000
S 3ffff 00000
S 3ffff 00000
S 3ffff 00000
S 00000 00000
S 00000 00000
S 00000 00000
S 00000 00000
S 00000 00000
# real impulse walks taps 3 1 2 0, then imaginary impulse taps 3 1
E 000 000 000 000
E fe0 030 fe0 fd0
E 038 010 038 ff0
E 000 000 000 000
E 070 030 070 fd0
E 018 ff8 018 008
E fd0 fe0 030 fe0
E ff0 038 010 038
# full-scale negative, guard bits, then floor of small negative sums
E 020 ea0 ea0 020
E f90 df0 df0 f90
E f6f f4f f4f f70
E fff fff fff 000
E fff fff fff 000
# zero window after nonzero symbols
E 000 000 000 000

// File: compile.f
hw/mfPkg.sv
hw/symTimer.sv
hw/tapSequencer.sv
hw/sampleWindow.sv
hw/complexMac.sv
hw/mfFilter.sv
sim/mfFilterTb.sv

// File: Bender.yml
package:
  name: mf_filter

sources:
  # shared types first
  - hw/mfPkg.sv
  - hw/symTimer.sv
  - hw/tapSequencer.sv
  - hw/sampleWindow.sv
  - hw/complexMac.sv
  - hw/mfFilter.sv
  - target: simulation
    files:
      - sim/mfFilterTb.sv
